// File: design/cpu_pkg.sv
package cpu_pkg;

   localparam int DATA_W           = 16;
   localparam int NUM_REGS         = 4;
   localparam int NUM_PORTS        = 4;
   localparam int INSTR_FIFO_DEPTH = 4;   // Host starts with this many credits.
   localparam int PORT_FIFO_DEPTH  = 4;   // Execute starts with this many credits.

   // Opcodes; 9 to 15 decode as NOP.
   localparam logic [3:0] OP_NOP = 4'd0;
   localparam logic [3:0] OP_LDI = 4'd1;
   localparam logic [3:0] OP_ADD = 4'd2;
   localparam logic [3:0] OP_SUB = 4'd3;
   localparam logic [3:0] OP_AND = 4'd4;
   localparam logic [3:0] OP_OR  = 4'd5;
   localparam logic [3:0] OP_XOR = 4'd6;
   localparam logic [3:0] OP_SHL = 4'd7;
   localparam logic [3:0] OP_OUT = 4'd8;

   typedef struct packed {
      logic [3:0]                    op;
      logic [$clog2(NUM_REGS)-1:0]   rd;
      logic [$clog2(NUM_REGS)-1:0]   rs;
      logic [7:0]                    imm;
   } instr_t;

   // One port write on its way to the host.
   typedef struct packed {
      logic [$clog2(NUM_PORTS)-1:0]  port;
      logic [DATA_W-1:0]             data;
   } port_rec_t;

endpackage

// File: design/board_pkg.sv
package board_pkg;

   localparam int DIGITS   = 4;
   localparam int SCAN_DIV = 8;   // Cycles per lit digit.

   // Bit 0 is segment a, bit 6 is segment g, lit is 1.
   localparam logic [6:0] SEG_TABLE [16] = '{
      7'h3F,   // 0
      7'h06,
      7'h5B,
      7'h4F,
      7'h66,
      7'h6D,
      7'h7D,
      7'h07,
      7'h7F,
      7'h6F,
      7'h77,   // A
      7'h7C,
      7'h39,
      7'h5E,
      7'h79,
      7'h71    // F
   };

endpackage

// File: design/credit_fifo.sv
`timescale 1ns/1ns

module credit_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic     selected_clk,
   input  logic     res,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     not_empty,
   output logic     popped
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_pop;

   assign not_empty = count != '0;
   assign do_pop    = pop && not_empty;
   assign head      = mem[rd_ptr];   // Storage is flops, head is a register output.

   always_ff @(posedge selected_clk)
      if (push)
         mem[wr_ptr] <= push_data;

   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         popped <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count  <= count + CNT_W'(push) - CNT_W'(do_pop);
         popped <= do_pop;   // One credit back per pop.
      end

   // Sender must respect its credits.
   a_no_overflow: assert property (@(posedge selected_clk) disable iff (res)
      push |-> count != CNT_W'(DEPTH))
      else $error("credit_fifo: push while full");

   a_no_underflow: assert property (@(posedge selected_clk) disable iff (res)
      pop |-> not_empty)
      else $error("credit_fifo: pop while empty");

endmodule

// File: design/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
   input  logic                                 selected_clk,
   input  logic                                 res,
   input  logic                                 instr_valid,
   input  cpu_pkg::instr_t                      instr,
   output logic                                 instr_credit,
   input  logic                                 exec_hold,
   output logic                                 dec_valid,
   output logic [3:0]                           dec_op,
   output logic [$clog2(cpu_pkg::NUM_REGS)-1:0] dec_rd,
   output logic [$clog2(cpu_pkg::NUM_REGS)-1:0] dec_rs,
   output logic [7:0]                           dec_imm
);

   import cpu_pkg::*;

   instr_t fifo_head;
   logic   fifo_ne;
   logic   fifo_pop;
   logic   slot_free;

   // Slot refills when empty or when its op moves on this cycle.
   assign slot_free = !dec_valid || !exec_hold;
   assign fifo_pop  = fifo_ne && slot_free;

   credit_fifo #(
      .payload_t (instr_t),
      .DEPTH     (INSTR_FIFO_DEPTH)
   ) instr_fifo (
      .selected_clk (selected_clk),
      .res          (res),
      .push         (instr_valid),
      .push_data    (instr),
      .pop          (fifo_pop),
      .head         (fifo_head),
      .not_empty    (fifo_ne),
      .popped       (instr_credit)
   );

   always_ff @(posedge selected_clk or posedge res)
      if (res)
         dec_valid <= 1'b0;
      else if (slot_free)
         dec_valid <= fifo_ne;

   always_ff @(posedge selected_clk)
      if (fifo_pop)
      begin
         // Unused codes go down as NOP.
         dec_op  <= (fifo_head.op > OP_OUT) ? OP_NOP : fifo_head.op;
         dec_rd  <= fifo_head.rd;
         dec_rs  <= fifo_head.rs;
         dec_imm <= fifo_head.imm;
      end

endmodule

// File: design/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
   input  logic                                 selected_clk,
   input  logic                                 res,
   input  logic                                 dec_valid,
   input  logic [3:0]                           dec_op,
   input  logic [$clog2(cpu_pkg::NUM_REGS)-1:0] dec_rd,
   input  logic [$clog2(cpu_pkg::NUM_REGS)-1:0] dec_rs,
   input  logic [7:0]                           dec_imm,
   output logic                                 exec_hold,
   output logic                                 wr_valid,
   output cpu_pkg::port_rec_t                   wr_rec,
   input  logic                                 wr_credit
);

   import cpu_pkg::*;

   localparam int CRED_W = $clog2(PORT_FIFO_DEPTH + 1);

   logic [DATA_W-1:0] regs [NUM_REGS];
   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] result;
   logic [CRED_W-1:0] credits;
   logic              is_out;
   logic              fire;
   logic              writes_rd;

   assign is_out    = dec_op == OP_OUT;
   assign exec_hold = dec_valid && is_out && credits == '0;   // OUT waits for room.
   assign fire      = dec_valid && !exec_hold;
   assign writes_rd = dec_op inside {[OP_LDI:OP_SHL]};

   assign op_a = regs[dec_rd];
   assign op_b = regs[dec_rs];

   always_comb
      case (dec_op)
         OP_LDI:  result = {{(DATA_W - 8){1'b0}}, dec_imm};
         OP_ADD:  result = op_a + op_b;
         OP_SUB:  result = op_a - op_b;
         OP_AND:  result = op_a & op_b;
         OP_OR:   result = op_a | op_b;
         OP_XOR:  result = op_a ^ op_b;
         OP_SHL:  result = {op_a[DATA_W-2:0], 1'b0};
         default: result = op_a;
      endcase

   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (fire && writes_rd)
         regs[dec_rd] <= result;

   // Credit is taken when the OUT issues, not when the record lands.
   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         credits  <= CRED_W'(PORT_FIFO_DEPTH);
         wr_valid <= 1'b0;
      end
      else
      begin
         credits  <= credits + CRED_W'(wr_credit) - CRED_W'(fire && is_out);
         wr_valid <= fire && is_out;
      end

   always_ff @(posedge selected_clk)
      if (fire && is_out)
      begin
         wr_rec.port <= dec_imm[$clog2(NUM_PORTS)-1:0];
         wr_rec.data <= op_a;
      end

   a_wr_has_credit: assert property (@(posedge selected_clk) disable iff (res)
      wr_valid |-> $past(credits) != '0)
      else $error("alu_execute: port write without credit");

   // Result must never hand back more than its buffer holds.
   a_credit_bound: assert property (@(posedge selected_clk) disable iff (res)
      credits <= CRED_W'(PORT_FIFO_DEPTH))
      else $error("alu_execute: credit count above buffer depth");

endmodule

// File: design/port_result.sv
`timescale 1ns/1ns

module port_result (
   input  logic                                  selected_clk,
   input  logic                                  res,
   input  logic                                  wr_valid,
   input  cpu_pkg::port_rec_t                    wr_rec,
   output logic                                  wr_credit,
   input  logic                                  port_credit,
   output logic                                  port_valid,
   output logic [$clog2(cpu_pkg::NUM_PORTS)-1:0] port_index,
   output logic [cpu_pkg::DATA_W-1:0]            port_data,
   input  logic [$clog2(cpu_pkg::NUM_PORTS)-1:0] display_sel,
   output logic [cpu_pkg::DATA_W-1:0]            display_data
);

   import cpu_pkg::*;

   logic [DATA_W-1:0] ports [NUM_PORTS];
   logic [DATA_W-1:0] host_credits;   // Granted minus used.
   port_rec_t         fifo_head;
   logic              fifo_ne;
   logic              fifo_pop;

   assign fifo_pop     = fifo_ne && host_credits != '0;
   assign display_data = ports[display_sel];

   credit_fifo #(
      .payload_t (port_rec_t),
      .DEPTH     (PORT_FIFO_DEPTH)
   ) port_fifo (
      .selected_clk (selected_clk),
      .res          (res),
      .push         (wr_valid),
      .push_data    (wr_rec),
      .pop          (fifo_pop),
      .head         (fifo_head),
      .not_empty    (fifo_ne),
      .popped       (wr_credit)
   );

   // Display side sees the value as soon as the record arrives.
   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         for (int i = 0; i < NUM_PORTS; i++)
            ports[i] <= '0;
      end
      else if (wr_valid)
         ports[wr_rec.port] <= wr_rec.data;

   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         host_credits <= '0;
         port_valid   <= 1'b0;
      end
      else
      begin
         host_credits <= host_credits + DATA_W'(port_credit) - DATA_W'(fifo_pop);
         port_valid   <= fifo_pop;
      end

   always_ff @(posedge selected_clk)
      if (fifo_pop)
      begin
         port_index <= fifo_head.port;
         port_data  <= fifo_head.data;
      end

endmodule

// File: design/seg7_scan.sv
`timescale 1ns/1ns

module seg7_scan (
   input  logic                            selected_clk,
   input  logic                            res,
   input  logic [4*board_pkg::DIGITS-1:0]  display_data,
   output logic [6:0]                      seg,
   output logic [board_pkg::DIGITS-1:0]    an
);

   import board_pkg::*;

   localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
   localparam int DIG_W = (DIGITS > 1) ? $clog2(DIGITS) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic [DIG_W-1:0] digit;
   logic [3:0]       nibble;
   logic             digit_end;

   assign digit_end = div_cnt == DIV_W'(SCAN_DIV - 1);
   assign nibble    = display_data[4*digit +: 4];

   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         div_cnt <= '0;
         digit   <= '0;
      end
      else
      begin
         div_cnt <= digit_end ? '0 : div_cnt + 1'b1;
         if (digit_end)
            digit <= (digit == DIG_W'(DIGITS - 1)) ? '0 : digit + 1'b1;
      end

   // Outputs trail the counters by one cycle, dark right after reset.
   always_ff @(posedge selected_clk or posedge res)
      if (res)
      begin
         an  <= '0;
         seg <= '0;
      end
      else
      begin
         an  <= DIGITS'(1) << digit;
         seg <= SEG_TABLE[nibble];
      end

endmodule

// File: design/bool_top.sv
`timescale 1ns/1ns

module bool_top (
   input  logic                                  selected_clk,
   input  logic                                  res,
   input  logic                                  instr_valid,
   input  cpu_pkg::instr_t                       instr,
   output logic                                  instr_credit,
   output logic                                  port_valid,
   output logic [$clog2(cpu_pkg::NUM_PORTS)-1:0] port_index,
   output logic [cpu_pkg::DATA_W-1:0]            port_data,
   input  logic                                  port_credit,
   input  logic [$clog2(cpu_pkg::NUM_PORTS)-1:0] display_sel,
   output logic [6:0]                            seg,
   output logic [board_pkg::DIGITS-1:0]          an
);

   import cpu_pkg::*;

   logic                        dec_valid;
   logic [3:0]                  dec_op;
   logic [$clog2(NUM_REGS)-1:0] dec_rd;
   logic [$clog2(NUM_REGS)-1:0] dec_rs;
   logic [7:0]                  dec_imm;
   logic                        exec_hold;
   logic                        wr_valid;
   port_rec_t                   wr_rec;
   logic                        wr_credit;
   logic [DATA_W-1:0]           display_data;

   instr_decode decode (
      .selected_clk (selected_clk),
      .res          (res),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_credit (instr_credit),
      .exec_hold    (exec_hold),
      .dec_valid    (dec_valid),
      .dec_op       (dec_op),
      .dec_rd       (dec_rd),
      .dec_rs       (dec_rs),
      .dec_imm      (dec_imm)
   );

   alu_execute execute (
      .selected_clk (selected_clk),
      .res          (res),
      .dec_valid    (dec_valid),
      .dec_op       (dec_op),
      .dec_rd       (dec_rd),
      .dec_rs       (dec_rs),
      .dec_imm      (dec_imm),
      .exec_hold    (exec_hold),
      .wr_valid     (wr_valid),
      .wr_rec       (wr_rec),
      .wr_credit    (wr_credit)
   );

   port_result result (
      .selected_clk (selected_clk),
      .res          (res),
      .wr_valid     (wr_valid),
      .wr_rec       (wr_rec),
      .wr_credit    (wr_credit),
      .port_credit  (port_credit),
      .port_valid   (port_valid),
      .port_index   (port_index),
      .port_data    (port_data),
      .display_sel  (display_sel),
      .display_data (display_data)
   );

   seg7_scan seg7drv (
      .selected_clk (selected_clk),
      .res          (res),
      .display_data (display_data),
      .seg          (seg),
      .an           (an)
   );

endmodule

// File: test/bool_checker.sv
`timescale 1ns/1ns

module bool_checker (
   input logic                                  selected_clk,
   input logic                                  res,
   input logic                                  instr_valid,
   input cpu_pkg::instr_t                       instr,
   input logic                                  instr_credit,
   input logic                                  port_valid,
   input logic [$clog2(cpu_pkg::NUM_PORTS)-1:0] port_index,
   input logic [cpu_pkg::DATA_W-1:0]            port_data,
   input logic                                  port_credit,
   input logic [$clog2(cpu_pkg::NUM_PORTS)-1:0] display_sel,
   input logic                                  display_check,
   input logic [6:0]                            seg,
   input logic [board_pkg::DIGITS-1:0]          an
);

   import cpu_pkg::*;
   import board_pkg::*;

   logic [DATA_W-1:0] regs [NUM_REGS];
   logic [DATA_W-1:0] ports [NUM_PORTS];
   port_rec_t         expected [$];   // OUT records not yet seen on the port channel.
   int                err_cnt [5] = '{default: 0};
   int                accepted = 0;
   int                out_count = 0;
   int                port_beats = 0;
   int                credit_total = 0;
   int                outstanding = 0;
   int                host_balance = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   logic              prev_res = 1'b0;

   task automatic flag_error(input int test, input string msg);
      err_cnt[test]++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   // Reference ISA.
   task automatic apply_instr(input instr_t i);
      port_rec_t rec;
      case (i.op)
         OP_LDI: regs[i.rd] = {8'h00, i.imm};
         OP_ADD: regs[i.rd] = regs[i.rd] + regs[i.rs];
         OP_SUB: regs[i.rd] = regs[i.rd] - regs[i.rs];
         OP_AND: regs[i.rd] = regs[i.rd] & regs[i.rs];
         OP_OR:  regs[i.rd] = regs[i.rd] | regs[i.rs];
         OP_XOR: regs[i.rd] = regs[i.rd] ^ regs[i.rs];
         OP_SHL: regs[i.rd] = regs[i.rd] << 1;
         OP_OUT:
         begin
            rec.port = i.imm[1:0];
            rec.data = regs[i.rd];
            ports[rec.port] = rec.data;
            expected.push_back(rec);
            out_count++;
         end
         default: ;   // NOP and unused codes.
      endcase
   endtask

   task automatic check_display();
      logic [DATA_W-1:0] word;
      logic [3:0]        nib;
      int                lit;
      int                lit_cnt;
      lit = 0;
      lit_cnt = 0;
      for (int k = 0; k < DIGITS; k++)
         if (an[k])
         begin
            lit_cnt++;
            lit = k;
         end
      if (lit_cnt != 1)
         flag_error(4, $sformatf("anodes %b are not one-hot", an));
      else
      begin
         word = ports[display_sel];
         nib = word[4*lit +: 4];
         if (seg !== SEG_TABLE[nib])
            flag_error(4, $sformatf("port %0d digit %0d seg %h, expected %h",
                                    display_sel, lit, seg, SEG_TABLE[nib]));
      end
   endtask

   always @(posedge selected_clk)
   begin
      if (res || prev_res)
         if (port_valid || instr_credit || seg != 0 || an != 0)
            flag_error(0, "outputs not idle in or right after reset");
      prev_res = res;
      if (res)
      begin
         for (int r = 0; r < NUM_REGS; r++)
            regs[r] = '0;
         for (int p = 0; p < NUM_PORTS; p++)
            ports[p] = '0;
         outstanding = 0;
         host_balance = 0;
      end
      else
      begin
         if (instr_credit)
         begin
            if (outstanding <= 0)
               flag_error(2, "instruction credit returned with nothing outstanding");
            credit_total++;
            outstanding--;
         end
         if (instr_valid)
         begin
            outstanding++;
            accepted++;
            apply_instr(instr);
         end
         if (port_valid)
         begin
            if (host_balance <= 0)
               flag_error(3, "port write sent with no host credit left");
            host_balance--;
            port_beats++;
            if (expected.size() == 0)
               flag_error(1, "port write with no OUT pending in the model");
            else if (port_index != expected[0].port || port_data != expected[0].data)
               flag_error(1, $sformatf("port write %0d:%h, expected %0d:%h", port_index,
                                       port_data, expected[0].port, expected[0].data));
            if (expected.size() != 0)
               void'(expected.pop_front());
         end
         if (port_credit)
            host_balance++;
         if (display_check)
            check_display();
      end
   end

   task automatic check_drain(input int n);
      if (accepted != n)
         flag_error(2, $sformatf("%0d instructions accepted, expected %0d", accepted, n));
      if (credit_total != n)
         flag_error(2, $sformatf("%0d credits returned, expected %0d", credit_total, n));
      if (port_beats != out_count)
         flag_error(3, $sformatf("%0d port writes, expected %0d", port_beats, out_count));
   endtask

   task automatic end_test(input int test, input string name);
      tests_run++;
      if (err_cnt[test] == 0)
         $display("Test %s: passed", name);
      else
      begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", name, err_cnt[test]);
      end
   endtask

   function automatic int total_errors();
      int sum;
      sum = 0;
      foreach (err_cnt[t])
         sum += err_cnt[t];
      return sum;
   endfunction

   task automatic summary();
      $display("Tests run %0d, failed %0d, errors %0d, port writes %0d",
               tests_run, tests_failed, total_errors(), port_beats);
   endtask

endmodule

// File: test/tb_bool_top.sv
`timescale 1ns/1ns

module tb_bool_top;

   import cpu_pkg::*;
   import board_pkg::*;

   localparam int N_INSTR        = 300;
   localparam int TIMEOUT_CYCLES = N_INSTR * 60 + 2000;   // Worst case stalls on every OUT.
   localparam int DRAIN_LIMIT    = 500;   // Far beyond the depth of both buffers.

   logic                        selected_clk;
   logic                        res;
   logic                        instr_valid;
   instr_t                      instr;
   logic                        instr_credit;
   logic                        port_valid;
   logic [$clog2(NUM_PORTS)-1:0] port_index;
   logic [DATA_W-1:0]           port_data;
   logic                        port_credit;
   logic [$clog2(NUM_PORTS)-1:0] display_sel;
   logic                        display_check;
   logic [6:0]                  seg;
   logic [DIGITS-1:0]           an;
   int unsigned                 seed;
   int                          credits;
   int                          sent;
   int                          stall;
   int                          cycles;
   int                          drain_cycles;
   logic                        drain;

   bool_top bool_top_inst (
      .selected_clk (selected_clk),
      .res          (res),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_credit (instr_credit),
      .port_valid   (port_valid),
      .port_index   (port_index),
      .port_data    (port_data),
      .port_credit  (port_credit),
      .display_sel  (display_sel),
      .seg          (seg),
      .an           (an)
   );

   bool_checker chk (
      .selected_clk  (selected_clk),
      .res           (res),
      .instr_valid   (instr_valid),
      .instr         (instr),
      .instr_credit  (instr_credit),
      .port_valid    (port_valid),
      .port_index    (port_index),
      .port_data     (port_data),
      .port_credit   (port_credit),
      .display_sel   (display_sel),
      .display_check (display_check),
      .seg           (seg),
      .an            (an)
   );

   initial
   begin
      selected_clk = 1'b0;
      forever #20 selected_clk = ~selected_clk;
   end

   // Roughly a quarter OUT.
   function automatic instr_t random_instr();
      instr_t i;
      i = 16'($urandom);
      if ($urandom % 4 == 0)
         i.op = OP_OUT;
      else if (i.op == OP_OUT)
         i.op = OP_LDI;
      return i;
   endfunction

   // One falling edge of host activity on both channels.
   task automatic drive_cycle();
      @(negedge selected_clk);
      if (instr_credit)
         credits++;
      instr_valid = 1'b0;
      if (sent < N_INSTR && credits > 0 && $urandom % 4 != 0)
      begin
         instr = random_instr();
         instr_valid = 1'b1;
         credits--;
         sent++;
      end
      if (drain)
         port_credit = 1'b1;
      else if (stall > 0)
      begin
         port_credit = 1'b0;
         stall--;
      end
      else
      begin
         port_credit = ($urandom % 2) == 0;
         if ($urandom % 16 == 0)
            stall = 20 + $urandom % 60;   // Long host stall.
      end
   endtask

   initial
   begin
      seed = 32'hd7b7cd23;
      void'($urandom(seed));
      res = 1'b1;
      instr_valid = 1'b0;
      instr = '0;
      port_credit = 1'b0;
      display_sel = '0;
      display_check = 1'b0;
      drain = 1'b0;
      credits = INSTR_FIFO_DEPTH;
      sent = 0;
      stall = 0;
      repeat (4) @(negedge selected_clk);
      res = 1'b0;
      drive_cycle();
      chk.end_test(0, "reset");
      while (sent < N_INSTR)
         drive_cycle();
      drain = 1'b1;
      drain_cycles = 0;
      while (!(credits == INSTR_FIFO_DEPTH && chk.port_beats == chk.out_count)
             && drain_cycles < DRAIN_LIMIT)
      begin
         drive_cycle();
         drain_cycles++;
      end
      repeat (4) drive_cycle();
      chk.check_drain(N_INSTR);
      chk.end_test(1, "execution");
      chk.end_test(2, "instruction credits");
      chk.end_test(3, "port credits");
      for (int s = 0; s < NUM_PORTS; s++)
      begin
         display_sel = s;
         repeat (2) drive_cycle();   // Let seg catch up with the new port.
         display_check = 1'b1;
         repeat (DIGITS * SCAN_DIV) drive_cycle();
         display_check = 1'b0;
      end
      chk.end_test(4, "display");
      chk.summary();
      if (chk.total_errors() == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge selected_clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: vlog.f
design/cpu_pkg.sv
design/board_pkg.sv
design/credit_fifo.sv
design/instr_decode.sv
design/alu_execute.sv
design/port_result.sv
design/seg7_scan.sv
design/bool_top.sv
test/bool_checker.sv
test/tb_bool_top.sv
